// ==== hdl/ooo_config_pkg.sv ====
//////////////////////////////
// machine sizes
//////////////////////////////

package ooo_config_pkg;

    // instructions handled per cycle at dispatch, completion and retirement
    localparam int n_way = 2;

    // reorder buffer entries
    localparam int rob_depth = 8;
    localparam int rob_ptr_w = 3;
    // open-entry count runs 0 .. rob_depth
    localparam int rob_count_w = 4;

    // register files
    localparam int arch_regs = 8;
    localparam int phys_regs = 16;
    localparam int arch_idx_w = 3;
    localparam int phys_idx_w = 4;

    // free list holds every tag not mapped architecturally
    localparam int free_depth = phys_regs - arch_regs;
    localparam int free_ptr_w = 3;
    localparam int free_count_w = 4;

    // per-cycle counts 0 .. n_way
    localparam int count_w = 2;

endpackage

// ==== hdl/ooo_types_pkg.sv ====
//////////////////////////////
// stage packets
//////////////////////////////

package ooo_types_pkg;

    // decoded instruction as offered by the front end
    // valid slots form a prefix, slot 0 oldest
    typedef struct packed {
        logic                                  valid;
        logic [ooo_config_pkg::arch_idx_w-1:0] dest_arch;
    } decoded_inst;

    // one reorder buffer slot
    // t_new is the tag given at rename, t_old the tag it replaced
    typedef struct packed {
        logic [ooo_config_pkg::arch_idx_w-1:0] dest_arch;
        logic [ooo_config_pkg::phys_idx_w-1:0] t_new;
        logic [ooo_config_pkg::phys_idx_w-1:0] t_old;
        logic                                  complete;
    } rob_entry;

    // completion broadcast from a functional unit
    typedef struct packed {
        logic                                  valid;
        logic [ooo_config_pkg::phys_idx_w-1:0] tag;
    } complete_tag;

    // what leaves the reorder buffer at retirement
    // t_new goes to the architectural map, t_old back to the free list
    typedef struct packed {
        logic [ooo_config_pkg::arch_idx_w-1:0] dest_arch;
        logic [ooo_config_pkg::phys_idx_w-1:0] t_new;
        logic [ooo_config_pkg::phys_idx_w-1:0] t_old;
    } retire_info;

endpackage

// ==== hdl/rename_dispatch.sv ====
//////////////////////////////
// rename and dispatch
//////////////////////////////

`timescale 1ns/1ns

module rename_dispatch (
    input  logic clock,
    input  logic reset,
    input  ooo_types_pkg::decoded_inst [ooo_config_pkg::n_way-1:0] insts,
    input  logic [ooo_config_pkg::rob_count_w-1:0] open_entries,
    input  logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] free_tags,
    output logic [ooo_config_pkg::count_w-1:0] num_accept,
    output ooo_types_pkg::rob_entry [ooo_config_pkg::n_way-1:0] wr_data,
    output logic [ooo_config_pkg::count_w-1:0] pop_count,
    output logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] new_tags
);

    // speculative map table holds the newest phys tag per arch reg
    logic [ooo_config_pkg::arch_regs-1:0][ooo_config_pkg::phys_idx_w-1:0] spec_map;
    logic [ooo_config_pkg::arch_regs-1:0][ooo_config_pkg::phys_idx_w-1:0] next_map;

    // length of the valid prefix offered this cycle
    logic [ooo_config_pkg::count_w-1:0] valid_cnt;
    logic                               prefix_run;

    // valid prefix count
    always_comb begin
        valid_cnt = '0;
        prefix_run = 1'b1;
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            if (prefix_run && insts[i].valid) begin
                valid_cnt = valid_cnt + 1'b1;
            end else begin
                prefix_run = 1'b0;
            end
        end
    end

    // accept min(valid prefix, open entries)
    // open_entries already includes what retires this cycle
    always_comb begin
        if (ooo_config_pkg::rob_count_w'(valid_cnt) <= open_entries) begin
            num_accept = valid_cnt;
        end else begin
            num_accept = ooo_config_pkg::count_w'(open_entries);
        end
    end

    // one free tag per accepted instruction in free list order
    assign pop_count = num_accept;

    // packets take t_old from the map with forwarding inside the group
    always_comb begin
        wr_data = '0;
        new_tags = '0;
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            wr_data[i].dest_arch = insts[i].dest_arch;
            wr_data[i].t_new = free_tags[i];
            wr_data[i].t_old = spec_map[insts[i].dest_arch];
            wr_data[i].complete = 1'b0;
            // an older slot in the same group writing this reg wins
            for (int j = 0; j < i; j++) begin
                if (insts[j].dest_arch == insts[i].dest_arch) begin
                    wr_data[i].t_old = free_tags[j];
                end
            end
            if (i < num_accept) begin
                new_tags[i] = free_tags[i];
            end
        end
    end

    // map update applied oldest first so the youngest write sticks
    always_comb begin
        next_map = spec_map;
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            if (i < num_accept) begin
                next_map[insts[i].dest_arch] = free_tags[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity mapping out of reset
            for (int r = 0; r < ooo_config_pkg::arch_regs; r++) begin
                spec_map[r] <= ooo_config_pkg::phys_idx_w'(r);
            end
        end else begin
            spec_map <= next_map;
        end
    end

endmodule

// ==== hdl/rob.sv ====
//////////////////////////////
// reorder buffer
//////////////////////////////

`timescale 1ns/1ns

module rob (
    input  logic clock,
    input  logic reset,
    input  ooo_types_pkg::rob_entry [ooo_config_pkg::n_way-1:0] wr_data,
    input  logic [ooo_config_pkg::count_w-1:0] num_accept,
    input  ooo_types_pkg::complete_tag [ooo_config_pkg::n_way-1:0] completes,
    output ooo_types_pkg::retire_info [ooo_config_pkg::n_way-1:0] retiring_data,
    output logic [ooo_config_pkg::count_w-1:0] num_retired,
    output logic [ooo_config_pkg::rob_count_w-1:0] open_entries
);

    // only the in-flight window of the entry storage is meaningful
    ooo_types_pkg::rob_entry [ooo_config_pkg::rob_depth-1:0] entries;

    // head is the oldest entry, tail one past the youngest
    logic [ooo_config_pkg::rob_ptr_w-1:0] head;
    logic [ooo_config_pkg::rob_ptr_w-1:0] tail;
    // occupancy count tells full from empty when head == tail
    logic [ooo_config_pkg::rob_count_w-1:0] count;

    logic [ooo_config_pkg::rob_depth-1:0] in_flight;
    logic [ooo_config_pkg::rob_depth-1:0] hit;
    logic [ooo_config_pkg::rob_ptr_w-1:0] age;
    logic [ooo_config_pkg::rob_ptr_w-1:0] slot;
    logic                                 retire_run;

    // in-flight mask and completion match
    // every live entry against every valid tag
    always_comb begin
        in_flight = '0;
        hit = '0;
        age = '0;
        for (int k = 0; k < ooo_config_pkg::rob_depth; k++) begin
            // distance from head wraps with the pointer width
            age = ooo_config_pkg::rob_ptr_w'(k) - head;
            in_flight[k] = ooo_config_pkg::rob_count_w'(age) < count;
            for (int c = 0; c < ooo_config_pkg::n_way; c++) begin
                if (in_flight[k] && completes[c].valid &&
                    entries[k].t_new == completes[c].tag) begin
                    hit[k] = 1'b1;
                end
            end
        end
    end

    // retire the longest completed prefix up to n_way
    always_comb begin
        retiring_data = '0;
        num_retired = '0;
        retire_run = 1'b1;
        slot = head;
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            slot = head + ooo_config_pkg::rob_ptr_w'(i);
            if (retire_run && ooo_config_pkg::rob_count_w'(i) < count &&
                entries[slot].complete) begin
                retiring_data[i].dest_arch = entries[slot].dest_arch;
                retiring_data[i].t_new = entries[slot].t_new;
                retiring_data[i].t_old = entries[slot].t_old;
                num_retired = num_retired + 1'b1;
            end else begin
                // first incomplete entry blocks everything younger
                retire_run = 1'b0;
            end
        end
    end

    // free space after this cycle's retirement
    assign open_entries = ooo_config_pkg::rob_count_w'(ooo_config_pkg::rob_depth) - count
                        + ooo_config_pkg::rob_count_w'(num_retired);

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            head <= head + ooo_config_pkg::rob_ptr_w'(num_retired);
            tail <= tail + ooo_config_pkg::rob_ptr_w'(num_accept);
            count <= count + ooo_config_pkg::rob_count_w'(num_accept)
                   - ooo_config_pkg::rob_count_w'(num_retired);
        end
    end

    // num_accept arrives already limited by dispatch
    always_ff @(posedge clock) begin
        for (int k = 0; k < ooo_config_pkg::rob_depth; k++) begin
            if (hit[k]) begin
                entries[k].complete <= 1'b1;
            end
        end
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            if (i < num_accept) begin
                entries[tail + ooo_config_pkg::rob_ptr_w'(i)] <= wr_data[i];
            end
        end
    end

endmodule

// ==== hdl/free_list.sv ====
//////////////////////////////
// physical tag free list
//////////////////////////////

`timescale 1ns/1ns

module free_list (
    input  logic clock,
    input  logic reset,
    input  logic [ooo_config_pkg::count_w-1:0] pop_count,
    input  logic [ooo_config_pkg::count_w-1:0] push_count,
    input  logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] push_tags,
    output logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] free_tags
);

    logic [ooo_config_pkg::free_depth-1:0][ooo_config_pkg::phys_idx_w-1:0] mem;
    logic [ooo_config_pkg::free_ptr_w-1:0]   head;
    logic [ooo_config_pkg::free_ptr_w-1:0]   tail;
    logic [ooo_config_pkg::free_count_w-1:0] count;

    // head of the queue as seen after this cycle's pushes
    // tags released this cycle queue up behind the stored ones
    // so a full rob can reuse them right away
    always_comb begin
        free_tags = '0;
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            if (ooo_config_pkg::free_count_w'(i) < count) begin
                free_tags[i] = mem[head + ooo_config_pkg::free_ptr_w'(i)];
            end else begin
                free_tags[i] = push_tags[i - int'(count)];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // tags arch_regs .. phys_regs-1 in ascending order
            for (int s = 0; s < ooo_config_pkg::free_depth; s++) begin
                mem[s] <= ooo_config_pkg::phys_idx_w'(ooo_config_pkg::arch_regs + s);
            end
            head <= '0;
            tail <= '0;
            count <= ooo_config_pkg::free_count_w'(ooo_config_pkg::free_depth);
        end else begin
            for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
                if (i < push_count) begin
                    mem[tail + ooo_config_pkg::free_ptr_w'(i)] <= push_tags[i];
                end
            end
            head <= head + ooo_config_pkg::free_ptr_w'(pop_count);
            tail <= tail + ooo_config_pkg::free_ptr_w'(push_count);
            count <= count + ooo_config_pkg::free_count_w'(push_count)
                   - ooo_config_pkg::free_count_w'(pop_count);
        end
    end

endmodule

// ==== hdl/retire_commit.sv ====
//////////////////////////////
// retirement commit
//////////////////////////////

`timescale 1ns/1ns

module retire_commit (
    input  logic clock,
    input  logic reset,
    input  ooo_types_pkg::retire_info [ooo_config_pkg::n_way-1:0] retiring_data,
    input  logic [ooo_config_pkg::count_w-1:0] num_retired,
    output logic [ooo_config_pkg::count_w-1:0] push_count,
    output logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] push_tags,
    output logic [ooo_config_pkg::arch_regs-1:0][ooo_config_pkg::phys_idx_w-1:0] arch_map
);

    logic [ooo_config_pkg::arch_regs-1:0][ooo_config_pkg::phys_idx_w-1:0] next_map;

    // every retired instruction frees the tag it displaced
    assign push_count = num_retired;

    always_comb begin
        push_tags = '0;
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            if (i < num_retired) begin
                push_tags[i] = retiring_data[i].t_old;
            end
        end
    end

    // oldest first so a younger write to the same reg lands last
    always_comb begin
        next_map = arch_map;
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            if (i < num_retired) begin
                next_map[retiring_data[i].dest_arch] = retiring_data[i].t_new;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < ooo_config_pkg::arch_regs; r++) begin
                arch_map[r] <= ooo_config_pkg::phys_idx_w'(r);
            end
        end else begin
            arch_map <= next_map;
        end
    end

endmodule

// ==== hdl/rob_subsystem.sv ====
//////////////////////////////
// rename, rob and retire top
//////////////////////////////

`timescale 1ns/1ns

module rob_subsystem (
    input  logic clock,
    input  logic reset,
    input  ooo_types_pkg::decoded_inst [ooo_config_pkg::n_way-1:0] dispatch_insts,
    input  ooo_types_pkg::complete_tag [ooo_config_pkg::n_way-1:0] completes,
    output logic [ooo_config_pkg::count_w-1:0] num_accepted,
    output logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] dispatch_tags,
    output ooo_types_pkg::retire_info [ooo_config_pkg::n_way-1:0] retired,
    output logic [ooo_config_pkg::count_w-1:0] num_retired,
    output logic [ooo_config_pkg::arch_regs-1:0][ooo_config_pkg::phys_idx_w-1:0] arch_map
);

    // dispatch side
    logic [ooo_config_pkg::rob_count_w-1:0]  open_entries;
    ooo_types_pkg::rob_entry [ooo_config_pkg::n_way-1:0] wr_data;
    logic [ooo_config_pkg::count_w-1:0]      pop_count;
    logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] free_tags;

    // retire side
    logic [ooo_config_pkg::count_w-1:0]      push_count;
    logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] push_tags;

    rename_dispatch rename_dispatch_i (
        .clock        (clock),
        .reset        (reset),
        .insts        (dispatch_insts),
        .open_entries (open_entries),
        .free_tags    (free_tags),
        .num_accept   (num_accepted),
        .wr_data      (wr_data),
        .pop_count    (pop_count),
        .new_tags     (dispatch_tags)
    );

    // retiring data goes straight out as well as into commit
    rob rob_i (
        .clock         (clock),
        .reset         (reset),
        .wr_data       (wr_data),
        .num_accept    (num_accepted),
        .completes     (completes),
        .retiring_data (retired),
        .num_retired   (num_retired),
        .open_entries  (open_entries)
    );

    free_list free_list_i (
        .clock      (clock),
        .reset      (reset),
        .pop_count  (pop_count),
        .push_count (push_count),
        .push_tags  (push_tags),
        .free_tags  (free_tags)
    );

    retire_commit retire_commit_i (
        .clock         (clock),
        .reset         (reset),
        .retiring_data (retired),
        .num_retired   (num_retired),
        .push_count    (push_count),
        .push_tags     (push_tags),
        .arch_map      (arch_map)
    );

endmodule

// ==== verif/rob_subsystem_assertions.sv ====
//////////////////////////////
// occupancy checks
//////////////////////////////

`timescale 1ns/1ns

module rob_subsystem_assertions #(
    parameter int depth = ooo_config_pkg::rob_depth,
    parameter bit idle_after_reset = 1'b0
) (
    input logic                                   clock,
    input logic                                   reset,
    // rob and free list counts share the same 4 bit width
    input logic [ooo_config_pkg::rob_count_w-1:0] occupancy,
    input logic [ooo_config_pkg::count_w-1:0]     take_count,
    input logic [ooo_config_pkg::count_w-1:0]     give_count
);

    // never more entries than storage
    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        occupancy <= depth)
        else $error("occupancy %0d above depth %0d", occupancy, depth);

    // what leaves in a cycle is held already or arrives in that same cycle
    take_bound: assert property (@(posedge clock) disable iff (reset)
        take_count <= occupancy + give_count)
        else $error("took %0d with %0d held and %0d arriving",
                    take_count, occupancy, give_count);

    // empty right after reset, so nothing leaves
    idle_check: assert property (@(posedge clock)
        (idle_after_reset && $past(reset) && !reset) |-> take_count == '0)
        else $error("count %0d in the first cycle after reset", take_count);

endmodule

bind rob rob_subsystem_assertions #(
    .depth            (ooo_config_pkg::rob_depth),
    .idle_after_reset (1'b1)
) rob_checks_i (
    .clock      (clock),
    .reset      (reset),
    .occupancy  (count),
    .take_count (num_retired),
    .give_count ('0)
);

bind free_list rob_subsystem_assertions #(
    .depth            (ooo_config_pkg::free_depth),
    .idle_after_reset (1'b0)
) free_list_checks_i (
    .clock      (clock),
    .reset      (reset),
    .occupancy  (count),
    .take_count (pop_count),
    .give_count (push_count)
);

// ==== verif/rob_subsystem_tb.sv ====
//////////////////////////////
// rob subsystem testbench
//////////////////////////////

`timescale 1ns/1ns

module rob_subsystem_tb;

    localparam int fill_cycles = 6;
    localparam int random_cycles = 400;
    localparam int drain_budget = 64;
    // reset, fill, traffic and drain, plus a margin of 100 cycles
    localparam int timeout_ns = (8 + fill_cycles + random_cycles + drain_budget + 100) * 100;

    logic clock;
    logic reset;
    ooo_types_pkg::decoded_inst [ooo_config_pkg::n_way-1:0] dispatch_insts;
    ooo_types_pkg::complete_tag [ooo_config_pkg::n_way-1:0] completes;
    logic [ooo_config_pkg::count_w-1:0] num_accepted;
    logic [ooo_config_pkg::n_way-1:0][ooo_config_pkg::phys_idx_w-1:0] dispatch_tags;
    ooo_types_pkg::retire_info [ooo_config_pkg::n_way-1:0] retired;
    logic [ooo_config_pkg::count_w-1:0] num_retired;
    logic [ooo_config_pkg::arch_regs-1:0][ooo_config_pkg::phys_idx_w-1:0] arch_map;

    // reference model advanced once per cycle just before the rising edge
    logic [ooo_config_pkg::phys_idx_w-1:0] spec_model [ooo_config_pkg::arch_regs];
    logic [ooo_config_pkg::phys_idx_w-1:0] arch_model [ooo_config_pkg::arch_regs];
    logic [ooo_config_pkg::phys_idx_w-1:0] free_q [$];
    // in-flight entries with the oldest first
    ooo_types_pkg::rob_entry fl_q [$];
    // instructions waiting to be accepted are re-offered oldest first
    logic [ooo_config_pkg::arch_idx_w-1:0] pending [$];
    int offer_cnt;
    int total_retired;
    bit checking;
    string test_name;
    integer seed;

    rob_subsystem dut_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_insts (dispatch_insts),
        .completes      (completes),
        .num_accepted   (num_accepted),
        .dispatch_tags  (dispatch_tags),
        .retired        (retired),
        .num_retired    (num_retired),
        .arch_map       (arch_map)
    );

    always #50 clock = ~clock;

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch in %s, %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            $display("Test failed");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    // longest run of completed entries at the head up to n_way
    function automatic int retire_prefix_len();
        int n;
        n = 0;
        while (n < ooo_config_pkg::n_way && n < fl_q.size() && fl_q[n].complete) begin
            n++;
        end
        return n;
    endfunction

    // valid prefix limited by the space left after this cycle's retirement
    function automatic int accept_limit(input int offered, input int open);
        if (offered < open) begin
            return offered;
        end
        return open;
    endfunction

    // map is updated slot by slot, so a later slot sees an earlier slot's tag
    function automatic logic [ooo_config_pkg::phys_idx_w-1:0] mapped_old_tag(
        input logic [ooo_config_pkg::arch_idx_w-1:0] dest
    );
        return spec_model[dest];
    endfunction

    // a tag about to be handed out must be neither in flight nor mapped
    function automatic int tag_uses(input logic [ooo_config_pkg::phys_idx_w-1:0] tag);
        int uses;
        uses = 0;
        foreach (fl_q[k]) begin
            if (fl_q[k].t_new == tag) begin
                uses++;
            end
        end
        for (int r = 0; r < ooo_config_pkg::arch_regs; r++) begin
            if (arch_model[r] == tag) begin
                uses++;
            end
        end
        return uses;
    endfunction

    // offer instructions and complete random in-flight tags
    task automatic drive_inputs(input bit offer, input bit fill_all, input bit complete);
        int cand[$];
        int pick;
        if (!offer) begin
            pending.delete();
        end
        while (offer && pending.size() < ooo_config_pkg::n_way &&
               (fill_all || {$random(seed)} % 4 != 0)) begin
            pending.push_back(ooo_config_pkg::arch_idx_w'({$random(seed)}));
        end
        offer_cnt = (pending.size() < ooo_config_pkg::n_way) ? pending.size()
                                                              : ooo_config_pkg::n_way;
        for (int i = 0; i < ooo_config_pkg::n_way; i++) begin
            dispatch_insts[i].valid = (i < offer_cnt);
            dispatch_insts[i].dest_arch = (i < offer_cnt) ? pending[i] : '0;
        end
        foreach (fl_q[k]) begin
            if (!fl_q[k].complete) begin
                cand.push_back(k);
            end
        end
        // picking from the whole incomplete set gives out-of-order completion
        for (int c = 0; c < ooo_config_pkg::n_way; c++) begin
            completes[c] = '0;
            if (complete && cand.size() > 0 && {$random(seed)} % 3 != 0) begin
                pick = {$random(seed)} % cand.size();
                completes[c].valid = 1'b1;
                completes[c].tag = fl_q[cand[pick]].t_new;
                cand.delete(pick);
            end
        end
    endtask

    // outputs settle by mid-cycle and the model then steps over the coming edge
    always @(negedge clock) begin : compare_outputs
        int nret;
        int nacc;
        int open;
        ooo_types_pkg::rob_entry ent;
        if (checking) begin
            nret = retire_prefix_len();
            check("num_retired", nret, num_retired);
            for (int i = 0; i < nret; i++) begin
                check("retired dest_arch", fl_q[i].dest_arch, retired[i].dest_arch);
                check("retired t_new", fl_q[i].t_new, retired[i].t_new);
                check("retired t_old", fl_q[i].t_old, retired[i].t_old);
            end
            for (int r = 0; r < ooo_config_pkg::arch_regs; r++) begin
                check("arch_map", arch_model[r], arch_map[r]);
            end
            open = ooo_config_pkg::rob_depth - fl_q.size() + nret;
            nacc = accept_limit(offer_cnt, open);
            check("num_accepted", nacc, num_accepted);
            // released tags queue up behind the ones still stored
            for (int i = 0; i < nret; i++) begin
                arch_model[fl_q[0].dest_arch] = fl_q[0].t_new;
                free_q.push_back(fl_q[0].t_old);
                void'(fl_q.pop_front());
                total_retired++;
            end
            for (int c = 0; c < ooo_config_pkg::n_way; c++) begin
                foreach (fl_q[k]) begin
                    if (completes[c].valid && fl_q[k].t_new == completes[c].tag) begin
                        ent = fl_q[k];
                        ent.complete = 1'b1;
                        fl_q[k] = ent;
                    end
                end
            end
            for (int i = 0; i < nacc; i++) begin
                check("tag reuse before release", 0, tag_uses(dispatch_tags[i]));
                ent.dest_arch = pending.pop_front();
                ent.t_new = free_q.pop_front();
                check("dispatch tag", ent.t_new, dispatch_tags[i]);
                ent.t_old = mapped_old_tag(ent.dest_arch);
                ent.complete = 1'b0;
                fl_q.push_back(ent);
                spec_model[ent.dest_arch] = ent.t_new;
            end
        end
    end

    initial begin : stimulus
        seed = 37934;
        clock = 1'b0;
        reset = 1'b1;
        dispatch_insts = '0;
        completes = '0;
        checking = 1'b0;
        offer_cnt = 0;
        total_retired = 0;
        test_name = "reset";
        // identity maps and tags arch_regs upward in the free list
        for (int r = 0; r < ooo_config_pkg::arch_regs; r++) begin
            spec_model[r] = ooo_config_pkg::phys_idx_w'(r);
            arch_model[r] = ooo_config_pkg::phys_idx_w'(r);
        end
        for (int t = ooo_config_pkg::arch_regs; t < ooo_config_pkg::phys_regs; t++) begin
            free_q.push_back(ooo_config_pkg::phys_idx_w'(t));
        end
        repeat (8) @(posedge clock);
        #5;
        reset = 1'b0;
        checking = 1'b1;
        // nothing completes, so the rob fills and accepting stops
        test_name = "fill";
        repeat (fill_cycles) begin
            drive_inputs(1'b1, 1'b1, 1'b0);
            @(posedge clock);
            #5;
        end
        check("accepted while full", 0, num_accepted);
        test_name = "random traffic";
        repeat (random_cycles) begin
            drive_inputs(1'b1, 1'b0, 1'b1);
            @(posedge clock);
            #5;
        end
        test_name = "drain";
        while (fl_q.size() != 0) begin
            drive_inputs(1'b0, 1'b0, 1'b1);
            @(posedge clock);
            #5;
        end
        drive_inputs(1'b0, 1'b0, 1'b0);
        // one more cycle so the final arch map is compared
        @(posedge clock);
        #5;
        checking = 1'b0;
        check("retired volume", 1, total_retired >= 4 * ooo_config_pkg::phys_regs);
        $display("Test completed successfully");
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("watchdog: run did not end within %0d ns", timeout_ns);
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

// ==== build.f ====
hdl/ooo_config_pkg.sv
hdl/ooo_types_pkg.sv
hdl/rename_dispatch.sv
hdl/rob.sv
hdl/free_list.sv
hdl/retire_commit.sv
hdl/rob_subsystem.sv
verif/rob_subsystem_assertions.sv
verif/rob_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run of the rob subsystem testbench

VERILATOR ?= verilator
TOP       ?= rob_subsystem_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
